// File: sources.f
common/pwmPkg.sv
design/busDecoder.sv
pwm/pwmTimer.sv
pwm/pwmChannel.sv
pwm/pwmDevice.sv
design/pwmPeripheral.sv
verif/pwmPeripheralTb.sv

// File: Bender.yml
package:
  name: pwm_peripheral

sources:
  - common/pwmPkg.sv
  - design/busDecoder.sv
  - pwm/pwmTimer.sv
  - pwm/pwmChannel.sv
  - pwm/pwmDevice.sv
  - design/pwmPeripheral.sv
  - target: test
    files:
      - verif/pwmPeripheralTb.sv

// File: verif/pwmPeripheralTb.sv
module pwmPeripheralTb;

	localparam int CLK_PERIOD = 8;
	localparam int unsigned SEED = 32'h0eb427da;
	localparam int CHANNELS = pwmPkg::OUTPUTS_PER_DEVICE;
	localparam int OUTPUTS = pwmPkg::DEVICE_COUNT * CHANNELS;
	localparam int DUTY_PERIODS = 2; // whole periods counted per channel
	localparam int PERIODS_WAITED = 8; // duty startup and window plus the interrupt waits

	logic clk;
	logic rstN;
	logic peripheralBus_we;
	logic peripheralBus_oe;
	logic [23:0] peripheralBus_address;
	logic [3:0] peripheralBus_byteSelect;
	logic [31:0] peripheralBus_dataWrite;
	logic [31:0] peripheralBus_dataRead;
	logic requestOutput;
	logic [OUTPUTS-1:0] pwm_en;
	logic [OUTPUTS-1:0] pwm_out;
	logic [pwmPkg::DEVICE_COUNT-1:0] pwm_irq;

	logic [31:0] regModel [pwmPkg::DEVICE_COUNT][8]; // indexed by offset / 4
	logic [OUTPUTS-1:0] expectedEn;
	logic [31:0] expectedRead;
	logic expectedRequest;
	logic readCheck;
	logic idleCheck;
	logic dutyDone;
	logic irqCheck;
	logic irqExpected;
	logic timeoutValid;
	int measuredHigh;
	int expectedHigh;
	int dutyOutput;
	int irqDevice;
	int errorCount;
	int testCount;
	int testErrors;
	int topValue;
	int divisor;
	int periodCycles;
	int compareValue [CHANNELS];
	longint timeoutLimit;

	pwmPeripheral pwmPeripheral_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	readDataCorrect: assert property (@(posedge clk) disable iff (!rstN)
		readCheck |-> peripheralBus_dataRead == expectedRead)
	else begin
		errorCount++;
		$display("mismatch at %0t: peripheralBus_dataRead = %h, expected %h", $time,
			$sampled(peripheralBus_dataRead), $sampled(expectedRead));
	end

	requestCorrect: assert property (@(posedge clk) disable iff (!rstN)
		(readCheck || !peripheralBus_oe) |-> requestOutput == (expectedRequest && readCheck))
	else begin
		errorCount++;
		$display("mismatch at %0t: requestOutput = %b, expected %b", $time,
			$sampled(requestOutput), $sampled(expectedRequest && readCheck));
	end

	enableCorrect: assert property (@(posedge clk) disable iff (!rstN) pwm_en == expectedEn)
	else begin
		errorCount++;
		$display("mismatch at %0t: pwm_en = %h, expected %h", $time, $sampled(pwm_en),
			$sampled(expectedEn));
	end

	idleOutputs: assert property (@(posedge clk) disable iff (!rstN)
		idleCheck |-> pwm_out == '0 && pwm_irq == '0)
	else begin
		errorCount++;
		$display("mismatch at %0t: pwm_out = %h pwm_irq = %h, expected 0 and 0", $time,
			$sampled(pwm_out), $sampled(pwm_irq));
	end

	dutyCorrect: assert property (@(posedge clk) dutyDone |-> measuredHigh == expectedHigh)
	else begin
		errorCount++;
		$display("mismatch at %0t: pwm_out[%0d] high cycles = %0d, expected %0d", $time,
			dutyOutput, $sampled(measuredHigh), $sampled(expectedHigh));
	end

	irqCorrect: assert property (@(posedge clk) disable iff (!rstN)
		irqCheck |-> pwm_irq[irqDevice] == irqExpected)
	else begin
		errorCount++;
		$display("mismatch at %0t: pwm_irq[%0d] = %b, expected %b", $time, irqDevice,
			$sampled(pwm_irq[irqDevice]), $sampled(irqExpected));
	end

	// writable bits of each register slot
	function automatic logic [31:0] fieldMask(input int slot);
		case (slot)
			0: return 32'h0000_FF03; // run, irq enable, divisor
			1: return 32'h0000_FFFF;
			2, 3: return 32'h0; // count is read only and status only clears
			default: return 32'h0001_FFFF; // compare value and enable
		endcase
	endfunction

	function automatic logic [23:0] regAddress(input int dev, input int slot);
		return {pwmPkg::PERIPHERAL_ID, 8'(dev + 1), 8'(slot * 4)};
	endfunction

	task automatic busWrite(input int dev, input int slot, input logic [3:0] bs,
			input logic [31:0] data);
		logic [31:0] laneMask;
		laneMask = {{8{bs[3]}}, {8{bs[2]}}, {8{bs[1]}}, {8{bs[0]}}} & fieldMask(slot);
		peripheralBus_we = 1'b1;
		peripheralBus_address = regAddress(dev, slot);
		peripheralBus_byteSelect = bs;
		peripheralBus_dataWrite = data;
		@(posedge clk);
		regModel[dev][slot] = (regModel[dev][slot] & ~laneMask) | (data & laneMask);
		if (slot >= 4)
			expectedEn[dev * CHANNELS + slot - 4] = regModel[dev][slot][16];
		@(negedge clk);
		peripheralBus_we = 1'b0;
	endtask

	task automatic busRead(input logic [23:0] address, input logic [31:0] expected,
			input logic request);
		peripheralBus_oe = 1'b1;
		peripheralBus_address = address;
		expectedRead = expected;
		expectedRequest = request;
		readCheck = 1'b1;
		@(negedge clk);
		peripheralBus_oe = 1'b0;
		readCheck = 1'b0;
	endtask

	task automatic waitIrqRise(input int dev, input int limit);
		for (int i = 0; i < limit && !pwm_irq[dev]; i++)
			@(negedge clk);
		irqCheck = 1'b1;
		irqExpected = 1'b1;
		@(negedge clk);
		irqCheck = 1'b0;
	endtask

	// counts high cycles per channel over whole periods from its first rising edge
	task automatic measureDuty(input int dev);
		int started [CHANNELS];
		int samples [CHANNELS];
		int high [CHANNELS];
		int window;
		int open;
		window = DUTY_PERIODS * periodCycles;
		for (int n = 0; n < CHANNELS; n++) begin
			started[n] = 0;
			samples[n] = 0;
			high[n] = 0;
		end
		open = CHANNELS;
		while (open > 0) begin
			@(negedge clk);
			open = 0;
			for (int n = 0; n < CHANNELS; n++) begin
				if (pwm_out[dev * CHANNELS + n])
					started[n] = 1;
				if (started[n] && samples[n] < window) begin
					samples[n]++;
					high[n] += pwm_out[dev * CHANNELS + n];
				end
				if (samples[n] < window)
					open++;
			end
		end
		for (int n = 0; n < CHANNELS; n++) begin
			dutyOutput = dev * CHANNELS + n;
			measuredHigh = high[n];
			expectedHigh = DUTY_PERIODS * (divisor + 1)
				* (compareValue[n] < topValue + 1 ? compareValue[n] : topValue + 1);
			dutyDone = 1'b1;
			@(negedge clk);
		end
		dutyDone = 1'b0;
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("test %0d %s finished with %0d errors", testCount, name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	initial begin
		int unsigned seed;
		int dev;
		int slot;
		seed = SEED;
		void'($urandom(seed));
		rstN = 1'b0;
		peripheralBus_we = 1'b0;
		peripheralBus_oe = 1'b0;
		peripheralBus_address = '0;
		peripheralBus_byteSelect = '0;
		peripheralBus_dataWrite = '0;
		{readCheck, idleCheck, dutyDone, irqCheck, irqExpected, expectedRequest} = '0;
		expectedRead = '0;
		expectedEn = '0;
		{measuredHigh, expectedHigh, dutyOutput, irqDevice} = '0;
		{errorCount, testCount, testErrors} = '0;
		for (int d = 0; d < pwmPkg::DEVICE_COUNT; d++)
			for (int s = 0; s < 8; s++)
				regModel[d][s] = '0;
		topValue = 3 + $urandom % 18; // keeps a period at 4 cycles or more
		divisor = $urandom % 4;
		for (int n = 0; n < CHANNELS; n++)
			compareValue[n] = 1 + $urandom % (topValue + 2);
		periodCycles = (topValue + 1) * (divisor + 1);
		timeoutLimit = 3 * PERIODS_WAITED * periodCycles * CLK_PERIOD + 2000;
		timeoutValid = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		idleCheck = 1'b1;
		for (int d = 0; d < pwmPkg::DEVICE_COUNT; d++)
			for (int s = 0; s < 8; s++)
				busRead(regAddress(d, s), 32'h0, 1'b1);
		idleCheck = 1'b0;
		endTest("reset");

		repeat (24) begin
			dev = $urandom % pwmPkg::DEVICE_COUNT;
			slot = $urandom % 6;
			if (slot >= 2)
				slot += 2; // skip count and status
			busWrite(dev, slot, 4'($urandom), $urandom);
			busRead(regAddress(dev, slot), regModel[dev][slot], 1'b1);
		end
		endTest("registers");

		busRead({pwmPkg::PERIPHERAL_ID ^ 8'($urandom % 255 + 1), 8'h01, 8'h00}, '1, 1'b0);
		busRead({pwmPkg::PERIPHERAL_ID, 8'h00, 8'(($urandom % 8) * 4)}, '1, 1'b0);
		busRead({pwmPkg::PERIPHERAL_ID, 8'(pwmPkg::DEVICE_COUNT + 1
			+ $urandom % (255 - pwmPkg::DEVICE_COUNT)), 8'h00}, '1, 1'b0);
		busRead({pwmPkg::PERIPHERAL_ID, 8'(1 + $urandom % pwmPkg::DEVICE_COUNT),
			8'(8'h20 + $urandom % 8'hE0)}, '1, 1'b0);
		busRead({pwmPkg::PERIPHERAL_ID, 8'h01, 8'h02}, '1, 1'b0); // not word aligned
		dev = $urandom % pwmPkg::DEVICE_COUNT;
		busRead(regAddress(dev, 1), regModel[dev][1], 1'b1);
		endTest("decoding");

		dev = $urandom % pwmPkg::DEVICE_COUNT;
		busWrite(dev, 0, 4'b0011, 32'(divisor) << 8); // stopped with the divisor loaded
		busWrite(dev, 1, 4'b0011, 32'(topValue));
		for (int n = 0; n < CHANNELS; n++)
			busWrite(dev, 4 + n, 4'b0111, 32'h0001_0000 | 32'(compareValue[n]));
		busWrite(dev, 0, 4'b0001, 32'h1);
		measureDuty(dev);
		endTest("duty cycle");

		irqDevice = dev;
		busWrite(dev, 0, 4'b0001, 32'h0);
		@(negedge clk); // a wrap from the last running cycle lands before the clear
		busWrite(dev, 3, 4'b0001, 32'h1); // drop the flag left by the duty run
		busRead(regAddress(dev, 3), 32'h0, 1'b1);
		busWrite(dev, 0, 4'b0001, 32'h3);
		waitIrqRise(dev, periodCycles + 4);
		busWrite(dev, 3, 4'b0001, 32'h1);
		irqCheck = 1'b1;
		irqExpected = 1'b0;
		@(negedge clk);
		irqCheck = 1'b0;
		waitIrqRise(dev, periodCycles + 4);
		busWrite(dev, 0, 4'b0001, 32'h1); // masked while the timer keeps wrapping
		irqCheck = 1'b1;
		irqExpected = 1'b0;
		repeat (periodCycles + 4) @(negedge clk);
		irqCheck = 1'b0;
		busRead(regAddress(dev, 3), 32'h1, 1'b1);
		endTest("interrupt");

		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		wait (timeoutValid === 1'b1);
		#(timeoutLimit);
		$display("timeout: the run did not finish within %0d time units", timeoutLimit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: design/pwmPeripheral.sv
module pwmPeripheral (
	input logic clk,
	input logic rstN,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input logic [23:0] peripheralBus_address,
	input logic [3:0] peripheralBus_byteSelect,
	input logic [31:0] peripheralBus_dataWrite,
	output logic [31:0] peripheralBus_dataRead,
	output logic requestOutput,
	output logic [pwmPkg::DEVICE_COUNT*pwmPkg::OUTPUTS_PER_DEVICE-1:0] pwm_en,
	output logic [pwmPkg::DEVICE_COUNT*pwmPkg::OUTPUTS_PER_DEVICE-1:0] pwm_out,
	output logic [pwmPkg::DEVICE_COUNT-1:0] pwm_irq
);

	logic [15:0] localAddress;
	logic peripheralEnable;
	logic [pwmPkg::DEVICE_COUNT-1:0] deviceRequest;
	logic [pwmPkg::DEVICE_COUNT-1:0][31:0] deviceData;

	busDecoder busDecoder_i (
		.clk(clk),
		.rstN(rstN),
		.peripheralBus_address(peripheralBus_address),
		.localAddress(localAddress),
		.peripheralEnable(peripheralEnable),
		.deviceRequest(deviceRequest),
		.deviceData(deviceData),
		.dataRead(peripheralBus_dataRead),
		.requestOutput(requestOutput)
	);

	for (genvar d = 0; d < pwmPkg::DEVICE_COUNT; d++) begin : device
		pwmDevice #(.DEVICE_INDEX(d)) pwmDevice_i (
			.clk(clk),
			.rstN(rstN),
			.peripheralEnable(peripheralEnable),
			.peripheralBus_we(peripheralBus_we),
			.peripheralBus_oe(peripheralBus_oe),
			.localAddress(localAddress),
			.peripheralBus_byteSelect(peripheralBus_byteSelect),
			.peripheralBus_dataWrite(peripheralBus_dataWrite),
			.dataRead(deviceData[d]),
			.requestOutput(deviceRequest[d]),
			.pwm_en(pwm_en[d*pwmPkg::OUTPUTS_PER_DEVICE +: pwmPkg::OUTPUTS_PER_DEVICE]),
			.pwm_out(pwm_out[d*pwmPkg::OUTPUTS_PER_DEVICE +: pwmPkg::OUTPUTS_PER_DEVICE]),
			.pwm_irq(pwm_irq[d])
		);
	end

endmodule

// File: pwm/pwmDevice.sv
module pwmDevice #(
	parameter int DEVICE_INDEX = 0
) (
	input logic clk,
	input logic rstN,
	input logic peripheralEnable,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input logic [15:0] localAddress,
	input logic [3:0] peripheralBus_byteSelect,
	input logic [31:0] peripheralBus_dataWrite,
	output logic [31:0] dataRead,
	output logic requestOutput,
	output logic [pwmPkg::OUTPUTS_PER_DEVICE-1:0] pwm_en,
	output logic [pwmPkg::OUTPUTS_PER_DEVICE-1:0] pwm_out,
	output logic pwm_irq
);

	logic deviceSelected;
	logic [7:0] regOffset;
	logic writeEnable;
	logic offsetMapped;
	logic [pwmPkg::OUTPUTS_PER_DEVICE-1:0] compareHit;
	logic [pwmPkg::OUTPUTS_PER_DEVICE-1:0][31:0] compareWords;

	logic run;
	logic irqEnable;
	logic [pwmPkg::PRESCALE_WIDTH-1:0] prescale;
	logic [pwmPkg::COUNTER_WIDTH-1:0] topValue;
	logic [pwmPkg::COUNTER_WIDTH-1:0] count;
	logic wrap;
	logic pending; // sticky wrap flag
	logic [31:0] configWord;

	// devices are numbered from 1 in address bits 15..8
	assign deviceSelected = peripheralEnable && (localAddress[15:8] == 8'(DEVICE_INDEX + 1));
	assign regOffset = localAddress[7:0];
	assign writeEnable = deviceSelected && peripheralBus_we;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			run <= 1'b0;
			irqEnable <= 1'b0;
			prescale <= '0;
			topValue <= '0;
		end else if (writeEnable) begin
			if (regOffset == pwmPkg::REG_CONFIG) begin
				if (peripheralBus_byteSelect[0]) begin
					run <= peripheralBus_dataWrite[pwmPkg::CFG_RUN_BIT];
					irqEnable <= peripheralBus_dataWrite[pwmPkg::CFG_IRQ_EN_BIT];
				end
				if (peripheralBus_byteSelect[1])
					prescale <= peripheralBus_dataWrite[pwmPkg::CFG_PRESCALE_LSB +: pwmPkg::PRESCALE_WIDTH];
			end
			if (regOffset == pwmPkg::REG_TOP) begin
				if (peripheralBus_byteSelect[0]) topValue[7:0] <= peripheralBus_dataWrite[7:0];
				if (peripheralBus_byteSelect[1]) topValue[15:8] <= peripheralBus_dataWrite[15:8];
			end
		end
	end

	// a wrap in the same cycle as the clear wins
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) pending <= 1'b0;
		else if (wrap) pending <= 1'b1;
		else if (writeEnable && regOffset == pwmPkg::REG_STATUS
				&& peripheralBus_byteSelect[0] && peripheralBus_dataWrite[0])
			pending <= 1'b0;
	end

	assign pwm_irq = pending && irqEnable;

	always_comb begin
		configWord = '0;
		configWord[pwmPkg::CFG_RUN_BIT] = run;
		configWord[pwmPkg::CFG_IRQ_EN_BIT] = irqEnable;
		configWord[pwmPkg::CFG_PRESCALE_LSB +: pwmPkg::PRESCALE_WIDTH] = prescale;
	end

	always_comb begin
		dataRead = '0;
		offsetMapped = 1'b1;
		case (regOffset)
			pwmPkg::REG_CONFIG: dataRead = configWord;
			pwmPkg::REG_TOP: dataRead[pwmPkg::COUNTER_WIDTH-1:0] = topValue;
			pwmPkg::REG_COUNT: dataRead[pwmPkg::COUNTER_WIDTH-1:0] = count; // read only
			pwmPkg::REG_STATUS: dataRead[0] = pending;
			default: begin
				offsetMapped = |compareHit;
				for (int n = 0; n < pwmPkg::OUTPUTS_PER_DEVICE; n++) begin
					if (compareHit[n]) dataRead = compareWords[n];
				end
			end
		endcase
	end

	assign requestOutput = deviceSelected && peripheralBus_oe && offsetMapped;

	pwmTimer pwmTimer_i (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.prescale(prescale),
		.top(topValue),
		.count(count),
		.wrap(wrap)
	);

	for (genvar n = 0; n < pwmPkg::OUTPUTS_PER_DEVICE; n++) begin : channel
		assign compareHit[n] = regOffset == 8'(pwmPkg::REG_COMPARE_BASE + 4 * n);

		pwmChannel pwmChannel_i (
			.clk(clk),
			.rstN(rstN),
			.write(writeEnable && compareHit[n]),
			.byteSelect(peripheralBus_byteSelect),
			.dataWrite(peripheralBus_dataWrite),
			.count(count),
			.run(run),
			.compareWord(compareWords[n]),
			.pwmEn(pwm_en[n]),
			.pwmOut(pwm_out[n])
		);
	end

	requestNeedsWindowAndOe: assert property (
		@(posedge clk) disable iff (!rstN) requestOutput |-> peripheralEnable && peripheralBus_oe
	) else $error("device %0d answered outside its window", DEVICE_INDEX + 1);

endmodule

// File: pwm/pwmChannel.sv
module pwmChannel (
	input logic clk,
	input logic rstN,
	input logic write,
	input logic [3:0] byteSelect,
	input logic [31:0] dataWrite,
	input logic [pwmPkg::COUNTER_WIDTH-1:0] count,
	input logic run,
	output logic [31:0] compareWord,
	output logic pwmEn,
	output logic pwmOut
);

	logic [pwmPkg::COUNTER_WIDTH-1:0] compareValue;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			compareValue <= '0;
			pwmEn <= 1'b0;
		end else if (write) begin
			if (byteSelect[0]) compareValue[7:0] <= dataWrite[7:0];
			if (byteSelect[1]) compareValue[15:8] <= dataWrite[15:8];
			if (byteSelect[2]) pwmEn <= dataWrite[pwmPkg::CMP_ENABLE_BIT];
		end
	end

	// compare above top keeps the output high for the whole period
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) pwmOut <= 1'b0;
		else pwmOut <= run && pwmEn && (count < compareValue);
	end

	always_comb begin
		compareWord = '0;
		compareWord[pwmPkg::COUNTER_WIDTH-1:0] = compareValue;
		compareWord[pwmPkg::CMP_ENABLE_BIT] = pwmEn;
	end

endmodule

// File: pwm/pwmTimer.sv
module pwmTimer (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic [pwmPkg::PRESCALE_WIDTH-1:0] prescale,
	input logic [pwmPkg::COUNTER_WIDTH-1:0] top,
	output logic [pwmPkg::COUNTER_WIDTH-1:0] count,
	output logic wrap
);

	logic [pwmPkg::PRESCALE_WIDTH-1:0] prescaleCount;
	logic advance;

	// >= keeps the prescaler from running away if the divisor is lowered mid-count
	assign advance = prescaleCount >= prescale;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			prescaleCount <= '0;
			count <= '0;
			wrap <= 1'b0;
		end else if (!run) begin
			prescaleCount <= '0; // stopped timer holds at zero
			count <= '0;
			wrap <= 1'b0;
		end else begin
			wrap <= 1'b0;
			if (advance) begin
				prescaleCount <= '0;
				if (count >= top) begin // also catches top lowered below count
					count <= '0;
					wrap <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end else begin
				prescaleCount <= prescaleCount + 1'b1;
			end
		end
	end

	noWrapWhenStopped: assert property (
		@(posedge clk) disable iff (!rstN) !run |=> !wrap
	) else $error("wrap pulsed after run was cleared");

	countHeldWhenStopped: assert property (
		@(posedge clk) disable iff (!rstN) !run |=> count == '0
	) else $error("count moved after run was cleared: %0d", count);

endmodule

// File: design/busDecoder.sv
module busDecoder (
	input logic clk, // assertion sampling only
	input logic rstN,
	input logic [23:0] peripheralBus_address,
	output logic [15:0] localAddress,
	output logic peripheralEnable,
	input logic [pwmPkg::DEVICE_COUNT-1:0] deviceRequest,
	input logic [pwmPkg::DEVICE_COUNT-1:0][31:0] deviceData,
	output logic [31:0] dataRead,
	output logic requestOutput
);

	logic [31:0] selectedData;

	assign peripheralEnable = peripheralBus_address[23:16] == pwmPkg::PERIPHERAL_ID;
	assign localAddress = peripheralBus_address[15:0]; // device field and register offset

	// and-or mux, relies on at most one device answering
	always_comb begin
		selectedData = '0;
		for (int d = 0; d < pwmPkg::DEVICE_COUNT; d++) begin
			selectedData = selectedData | (deviceData[d] & {32{deviceRequest[d]}});
		end
	end

	assign requestOutput = |deviceRequest;
	assign dataRead = requestOutput ? selectedData : pwmPkg::READ_DEFAULT;

	// every device checks its own field, so two answering at once means overlapping decode
	deviceRequestOneHot: assert property (
		@(posedge clk) disable iff (!rstN) $onehot0(deviceRequest)
	) else $error("more than one device answered: %b", deviceRequest);

endmodule

// File: common/pwmPkg.sv
package pwmPkg;

	// peripheral window in address bits 23..16
	localparam logic [7:0] PERIPHERAL_ID = 8'h02;

	localparam int DEVICE_COUNT = 4;
	localparam int OUTPUTS_PER_DEVICE = 4;

	localparam int COUNTER_WIDTH = 16; // timer and compare width
	localparam int PRESCALE_WIDTH = 8;

	// register byte offsets inside a device
	localparam logic [7:0] REG_CONFIG = 8'h00;
	localparam logic [7:0] REG_TOP = 8'h04;
	localparam logic [7:0] REG_COUNT = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;
	localparam logic [7:0] REG_COMPARE_BASE = 8'h10; // channel n at base + 4n

	// config register fields
	localparam int CFG_RUN_BIT = 0;
	localparam int CFG_IRQ_EN_BIT = 1;
	localparam int CFG_PRESCALE_LSB = 8; // divisor in bits 15..8

	// compare register enable bit
	localparam int CMP_ENABLE_BIT = 16;

	// bus value when nothing answers
	localparam logic [31:0] READ_DEFAULT = 32'hFFFF_FFFF;

endpackage
